// File: hdl/udp_hub_pkg.sv
package udp_hub_pkg;

   // number of local services sharing the core
   localparam int NUM_CHANNELS = 3;

   // listening ports, overridable from the top level
   localparam logic [15:0] DEFAULT_DHCP_PORT    = 16'd68;
   localparam logic [15:0] DEFAULT_CONTROL_PORT = 16'd18521;
   localparam logic [15:0] DEFAULT_STREAM_PORT  = 16'd18520;

   // result code returned by the core on the transmit side
   typedef enum logic [1:0] {
      tx_idle  = 2'd0,
      tx_busy  = 2'd1,
      tx_done  = 2'd2,
      tx_error = 2'd3
   } tx_result_e;

   // channel index, lower value wins arbitration
   typedef enum logic [1:0] {
      chan_dhcp    = 2'd0,
      chan_control = 2'd1,
      chan_stream  = 2'd2
   } chan_e;

   typedef struct packed {
      logic [7:0]  data;
      logic        start;
      logic        last;
      logic [15:0] dst_port;
      logic [15:0] src_port;
      logic [31:0] src_ip;
   } udp_rx_beat_t;

   typedef struct packed {
      logic [31:0] dst_ip;
      logic [15:0] dst_port;
      logic [15:0] src_port;
      logic [15:0] length;
   } udp_tx_hdr_t;

   // start/hdr follow the start/result exchange, valid/data/last the stream handshake
   typedef struct packed {
      logic        start;
      udp_tx_hdr_t hdr;
      logic        valid;
      logic [7:0]  data;
      logic        last;
   } udp_tx_req_t;

   typedef struct packed {
      logic       ready;
      tx_result_e result;
   } udp_tx_rsp_t;

endpackage

// File: hdl/udp_rx_dispatch.sv
`timescale 1ns/1ps

module udp_rx_dispatch #(
   parameter logic [15:0] dhcp_port    = udp_hub_pkg::DEFAULT_DHCP_PORT,
   parameter logic [15:0] control_port = udp_hub_pkg::DEFAULT_CONTROL_PORT,
   parameter logic [15:0] stream_port  = udp_hub_pkg::DEFAULT_STREAM_PORT
) (
   input  logic                                   m_axis_aclk,
   input  logic                                   m_axis_aresetn,
   input  logic                                   rx_valid,
   input  udp_hub_pkg::udp_rx_beat_t              rx_beat,
   output logic [udp_hub_pkg::NUM_CHANNELS-1:0]   rx_chan_valid,
   output udp_hub_pkg::udp_rx_beat_t              rx_out
);

   logic [udp_hub_pkg::NUM_CHANNELS-1:0] port_hit;

   // port decode, first match wins so the result stays one-hot
   always_comb begin
      port_hit = '0;
      if (rx_beat.dst_port == dhcp_port) begin
         port_hit[udp_hub_pkg::chan_dhcp] = 1'b1;
      end else if (rx_beat.dst_port == control_port) begin
         port_hit[udp_hub_pkg::chan_control] = 1'b1;
      end else if (rx_beat.dst_port == stream_port) begin
         port_hit[udp_hub_pkg::chan_stream] = 1'b1;
      end
   end

   // beat payload, shared by all services
   always_ff @(posedge m_axis_aclk) begin
      rx_out <= rx_beat;
   end

   // unknown ports leave every bit low and the beat is dropped
   always_ff @(posedge m_axis_aclk) begin
      if (!m_axis_aresetn) begin
         rx_chan_valid <= '0;
      end else if (rx_valid) begin
         rx_chan_valid <= port_hit;
      end else begin
         rx_chan_valid <= '0;
      end
   end

endmodule

// File: hdl/udp_tx_arbiter.sv
`timescale 1ns/1ps

module udp_tx_arbiter #(
   parameter logic [15:0] dhcp_port    = udp_hub_pkg::DEFAULT_DHCP_PORT,
   parameter logic [15:0] control_port = udp_hub_pkg::DEFAULT_CONTROL_PORT,
   parameter logic [15:0] stream_port  = udp_hub_pkg::DEFAULT_STREAM_PORT
) (
   input  logic                     m_axis_aclk,
   input  logic                     m_axis_aresetn,
   input  udp_hub_pkg::udp_tx_req_t chan_req [udp_hub_pkg::NUM_CHANNELS],
   output udp_hub_pkg::udp_tx_rsp_t chan_rsp [udp_hub_pkg::NUM_CHANNELS],
   output udp_hub_pkg::udp_tx_req_t core_req,
   input  logic                     core_ready,
   input  udp_hub_pkg::tx_result_e  core_result
);

   typedef enum logic [1:0] {
      arb_idle,
      arb_request,
      arb_send
   } arb_state_e;

   arb_state_e               state;
   udp_hub_pkg::chan_e       grant;
   udp_hub_pkg::chan_e       next_grant;
   logic                     any_start;
   logic                     granted;
   logic                     finished;
   logic [15:0]              grant_port;
   udp_hub_pkg::udp_tx_req_t sel_req;

   // fixed priority, dhcp before control before stream
   always_comb begin
      any_start  = 1'b1;
      next_grant = udp_hub_pkg::chan_dhcp;
      if (chan_req[udp_hub_pkg::chan_dhcp].start) begin
         next_grant = udp_hub_pkg::chan_dhcp;
      end else if (chan_req[udp_hub_pkg::chan_control].start) begin
         next_grant = udp_hub_pkg::chan_control;
      end else if (chan_req[udp_hub_pkg::chan_stream].start) begin
         next_grant = udp_hub_pkg::chan_stream;
      end else begin
         any_start = 1'b0;
      end
   end

   assign granted  = (state != arb_idle);
   assign finished = (core_result == udp_hub_pkg::tx_done) ||
                     (core_result == udp_hub_pkg::tx_error);

   always_ff @(posedge m_axis_aclk) begin
      if (!m_axis_aresetn) begin
         state <= arb_idle;
         grant <= udp_hub_pkg::chan_dhcp;
      end else begin
         case (state)
            arb_idle: begin
               if (any_start) begin
                  grant <= next_grant;
                  state <= arb_request;
               end
            end
            // start is held to the core until it answers
            arb_request: begin
               if (finished) begin
                  state <= arb_idle;
               end else if (core_result == udp_hub_pkg::tx_busy) begin
                  state <= arb_send;
               end
            end
            arb_send: begin
               if (finished) begin
                  state <= arb_idle;
               end
            end
            default: begin
               state <= arb_idle;
            end
         endcase
      end
   end

   // source port is owned by the hub, not the service
   always_comb begin
      case (grant)
         udp_hub_pkg::chan_control: grant_port = control_port;
         udp_hub_pkg::chan_stream:  grant_port = stream_port;
         default:                   grant_port = dhcp_port;
      endcase
   end

   assign sel_req = chan_req[grant];

   always_comb begin
      core_req              = sel_req;
      core_req.hdr.src_port = grant_port;
      core_req.start        = (state == arb_request);
      core_req.valid        = granted && sel_req.valid;
   end

   // ready and result go back to the granted service only
   always_comb begin
      for (int i = 0; i < udp_hub_pkg::NUM_CHANNELS; i++) begin
         chan_rsp[i].ready  = 1'b0;
         chan_rsp[i].result = udp_hub_pkg::tx_idle;
         if (granted && (int'(grant) == i)) begin
            chan_rsp[i].ready  = core_ready;
            chan_rsp[i].result = core_result;
         end
      end
   end

endmodule

// File: hdl/dhcp_kick_timer.sv
`timescale 1ns/1ps

module dhcp_kick_timer #(
   parameter int kick_delay = 7
) (
   input  logic m_axis_aclk,
   input  logic m_axis_aresetn,
   input  logic second_tick,
   input  logic do_dhcp,
   output logic dhcp_start
);

   localparam int CNT_W = $clog2(kick_delay + 1);

   logic [CNT_W-1:0] tick_cnt;
   logic             kick_done;
   logic             auto_kick;

   // high on the last tick of the delay, once per reset
   assign auto_kick = second_tick && !kick_done &&
                      (tick_cnt == CNT_W'(kick_delay - 1));

   always_ff @(posedge m_axis_aclk) begin
      if (!m_axis_aresetn) begin
         tick_cnt   <= '0;
         kick_done  <= 1'b0;
         dhcp_start <= 1'b0;
      end else begin
         if (second_tick && !kick_done) begin
            tick_cnt <= tick_cnt + 1'b1;
         end
         if (auto_kick) begin
            kick_done <= 1'b1;
         end
         // external requests pass straight through
         dhcp_start <= auto_kick || do_dhcp;
      end
   end

endmodule

// File: hdl/udp_port_hub.sv
`timescale 1ns/1ps

module udp_port_hub #(
   parameter logic [15:0] dhcp_port    = udp_hub_pkg::DEFAULT_DHCP_PORT,
   parameter logic [15:0] control_port = udp_hub_pkg::DEFAULT_CONTROL_PORT,
   parameter logic [15:0] stream_port  = udp_hub_pkg::DEFAULT_STREAM_PORT,
   parameter int          kick_delay   = 7
) (
   input  logic                                 m_axis_aclk,
   input  logic                                 m_axis_aresetn,
   // receive side from the core
   input  logic                                 rx_valid,
   input  udp_hub_pkg::udp_rx_beat_t            rx_beat,
   output logic [udp_hub_pkg::NUM_CHANNELS-1:0] rx_chan_valid,
   output udp_hub_pkg::udp_rx_beat_t            rx_out,
   // transmit side, services and core
   input  udp_hub_pkg::udp_tx_req_t             chan_req [udp_hub_pkg::NUM_CHANNELS],
   output udp_hub_pkg::udp_tx_rsp_t             chan_rsp [udp_hub_pkg::NUM_CHANNELS],
   output udp_hub_pkg::udp_tx_req_t             core_req,
   input  logic                                 core_ready,
   input  udp_hub_pkg::tx_result_e              core_result,
   // dhcp start
   input  logic                                 second_tick,
   input  logic                                 do_dhcp,
   output logic                                 dhcp_start
);

   udp_rx_dispatch #(
      .dhcp_port    (dhcp_port),
      .control_port (control_port),
      .stream_port  (stream_port)
   ) u_rx_dispatch (
      .m_axis_aclk    (m_axis_aclk),
      .m_axis_aresetn (m_axis_aresetn),
      .rx_valid       (rx_valid),
      .rx_beat        (rx_beat),
      .rx_chan_valid  (rx_chan_valid),
      .rx_out         (rx_out)
   );

   udp_tx_arbiter #(
      .dhcp_port    (dhcp_port),
      .control_port (control_port),
      .stream_port  (stream_port)
   ) u_tx_arbiter (
      .m_axis_aclk    (m_axis_aclk),
      .m_axis_aresetn (m_axis_aresetn),
      .chan_req       (chan_req),
      .chan_rsp       (chan_rsp),
      .core_req       (core_req),
      .core_ready     (core_ready),
      .core_result    (core_result)
   );

   dhcp_kick_timer #(
      .kick_delay (kick_delay)
   ) u_dhcp_kick (
      .m_axis_aclk    (m_axis_aclk),
      .m_axis_aresetn (m_axis_aresetn),
      .second_tick    (second_tick),
      .do_dhcp        (do_dhcp),
      .dhcp_start     (dhcp_start)
   );

endmodule

// File: bench/udp_port_hub_sva.sv
`timescale 1ns/1ps

module udp_port_hub_sva (
   input logic                                 m_axis_aclk,
   input logic                                 m_axis_aresetn,
   input logic [udp_hub_pkg::NUM_CHANNELS-1:0] onehot_vec,
   input logic                                 start,
   input logic                                 granted
);

   // per-channel flags, never more than one at a time
   flags_onehot: assert property (@(posedge m_axis_aclk) disable iff (!m_axis_aresetn)
      $onehot0(onehot_vec))
      else $error("more than one channel flag set: %b", onehot_vec);

   flags_known: assert property (@(posedge m_axis_aclk) disable iff (!m_axis_aresetn)
      !$isunknown(onehot_vec))
      else $error("channel flags unknown after reset");

   // start only on behalf of a granted, still requesting channel
   start_granted: assert property (@(posedge m_axis_aclk) disable iff (!m_axis_aresetn)
      start |-> granted)
      else $error("start raised while no channel is granted");

endmodule

// ready vector and core start of the arbiter
bind udp_tx_arbiter udp_port_hub_sva u_arb_sva (
   .m_axis_aclk    (m_axis_aclk),
   .m_axis_aresetn (m_axis_aresetn),
   .onehot_vec     ({chan_rsp[2].ready, chan_rsp[1].ready, chan_rsp[0].ready}),
   .start          (core_req.start),
   .granted        (granted && chan_req[grant].start)
);

// a receive channel flag only follows a beat for a listening port
bind udp_rx_dispatch udp_port_hub_sva u_rx_sva (
   .m_axis_aclk    (m_axis_aclk),
   .m_axis_aresetn (m_axis_aresetn),
   .onehot_vec     (rx_chan_valid),
   .start          (|rx_chan_valid),
   .granted        ((rx_out.dst_port == dhcp_port) ||
                    (rx_out.dst_port == control_port) ||
                    (rx_out.dst_port == stream_port))
);

// File: bench/udp_port_hub_tb.sv
`timescale 1ns/1ps

module udp_port_hub_tb;

   localparam int NCH        = udp_hub_pkg::NUM_CHANNELS;
   localparam int WAIT_LIMIT = 4000;

   logic                      m_axis_aclk = 1'b0;
   logic                      m_axis_aresetn;
   logic                      rx_valid;
   logic                      core_ready;
   logic                      second_tick;
   logic                      do_dhcp;
   logic                      dhcp_start;
   logic [NCH-1:0]            rx_chan_valid;
   udp_hub_pkg::udp_rx_beat_t rx_beat;
   udp_hub_pkg::udp_rx_beat_t rx_out;
   udp_hub_pkg::udp_tx_req_t  chan_req [NCH];
   udp_hub_pkg::udp_tx_rsp_t  chan_rsp [NCH];
   udp_hub_pkg::udp_tx_req_t  core_req;
   udp_hub_pkg::tx_result_e   core_result;
   integer                    seed = 32'h186f;
   integer                    fd;
   int                        f [6];
   int                        cmds;
   string                     op;
   string                     rest;

   udp_port_hub DUT (.*);

   always #20 m_axis_aclk = ~m_axis_aclk;

   task automatic abort_run(input string what);
      $display("%s", what);
      $display("Verification failed");
      $fatal(1, "run stopped");
   endtask

   task automatic compare_values(input string name, input logic [79:0] expected,
                                 input logic [79:0] actual);
      if (expected !== actual) begin
         abort_run($sformatf("FAILED %s: expected %0h, actual %0h", name, expected, actual));
      end
   endtask

   task automatic drive_edge();
      @(posedge m_axis_aclk);
      #1;
   endtask

   // listening ports of dhcp, control and stream
   function automatic logic [15:0] listen_port(input int ch);
      case (ch)
         0:       return 16'd68;
         1:       return 16'd18521;
         default: return 16'd18520;
      endcase
   endfunction

   function automatic logic [7:0] payload_byte(input int ch, input int idx);
      return 8'(ch * 64 + idx * 3 + 1);
   endfunction

   task automatic run_rx(input int port, input int data, input int first, input int last,
                         input int exp_valid);
      drive_edge();
      rx_valid = 1'b1;
      rx_beat  = {8'(data), 1'(first), 1'(last), 16'(port), 16'h3039, 32'h0a00_0002};
      drive_edge();
      rx_valid = 1'b0;
      @(negedge m_axis_aclk);
      compare_values("rx channel valid", exp_valid, rx_chan_valid);
      compare_values("rx beat", rx_beat, rx_out);
   endtask

   // services and core model advance one cycle per pass until every packet is answered
   task automatic run_tx(input int mask, input int len, input int res, input int o0,
                         input int o1, input int o2);
      int order [3];
      int idx [NCH];
      bit done [NCH];
      int remaining;
      int cur;
      int grants;
      int core_idx;
      int phase;
      int cycles;
      bit got_last;
      order     = '{o0, o1, o2};
      idx       = '{default: 0};
      done      = '{default: 0};
      remaining = $countones(mask[NCH-1:0]);
      cur       = -1;
      grants    = 0;
      core_idx  = 0;
      phase     = 0;
      cycles    = 0;
      got_last  = 1'b0;
      while (remaining > 0) begin
         drive_edge();
         for (int i = 0; i < NCH; i++) begin
            chan_req[i] = '0;
            if (mask[i] && !done[i]) begin
               chan_req[i].start = 1'b1;
               chan_req[i].hdr   = {32'(32'hc0a8_0010 + i), 16'(16'h1000 + i), 16'hffff,
                                    16'(len)};
               chan_req[i].valid = (idx[i] < len);
               chan_req[i].data  = payload_byte(i, idx[i]);
               chan_req[i].last  = (idx[i] == len - 1);
            end
         end
         // core: busy two cycles after start, result once the last byte is in
         core_ready = 1'($random(seed));
         case (phase)
            2: begin
               core_result = udp_hub_pkg::tx_busy;
               phase       = 3;
            end
            3: if (got_last) begin
               core_result = udp_hub_pkg::tx_result_e'(res);
               phase       = 4;
            end
            4: begin
               core_result = udp_hub_pkg::tx_idle;
               phase       = 0;
            end
            default: phase = (phase == 1) ? 2 : 0;
         endcase
         @(negedge m_axis_aclk);
         cycles++;
         if (cycles > WAIT_LIMIT) begin
            abort_run("timeout while waiting for the transmit results");
         end
         if (phase == 0 && core_req.start) begin
            cur = int'(core_req.hdr.dst_port) - 32'h1000;
            compare_values("tx grant order", (grants < 3) ? order[grants] : 3, cur);
            compare_values("tx source port", listen_port(cur), core_req.hdr.src_port);
            compare_values("tx length", len, core_req.hdr.length);
            compare_values("tx destination ip", 32'hc0a8_0010 + cur, core_req.hdr.dst_ip);
            grants++;
            core_idx = 0;
            got_last = 1'b0;
            phase    = 1;
         end
         if (cur < 0) begin
            compare_values("tx valid while idle", 0, core_req.valid);
         end
         if (core_req.valid && core_ready) begin
            compare_values("tx data", payload_byte(cur, core_idx), core_req.data);
            compare_values("tx last", core_idx == len - 1, core_req.last);
            got_last = core_req.last;
            core_idx++;
         end
         for (int i = 0; i < NCH; i++) begin
            compare_values("tx ready routing", (i == cur) ? core_ready : 1'b0,
                           chan_rsp[i].ready);
            compare_values("tx result routing",
                           (i == cur) ? core_result : udp_hub_pkg::tx_idle,
                           chan_rsp[i].result);
            if (chan_req[i].valid && chan_rsp[i].ready) begin
               idx[i]++;
            end
            if (mask[i] && !done[i] &&
                (chan_rsp[i].result == udp_hub_pkg::tx_done ||
                 chan_rsp[i].result == udp_hub_pkg::tx_error)) begin
               compare_values("tx result", res, chan_rsp[i].result);
               compare_values("tx bytes sent", len, idx[i]);
               done[i] = 1'b1;
               remaining--;
               cur = -1;
            end
         end
      end
      drive_edge();
      chan_req    = '{default: '0};
      core_ready  = 1'b0;
      core_result = udp_hub_pkg::tx_idle;
      compare_values("tx grant count", (o0 != 3) + (o1 != 3) + (o2 != 3), grants);
   endtask

   task automatic run_ticks(input int count, input int exp_pulses);
      int pulses;
      pulses = 0;
      repeat (count) begin
         for (int c = 0; c < 3; c++) begin
            drive_edge();
            second_tick = (c == 0);
            @(negedge m_axis_aclk);
            if (dhcp_start) begin
               compare_values("dhcp pulse after tick", 1, c);
               pulses++;
            end
         end
      end
      compare_values("dhcp automatic start pulses", exp_pulses, pulses);
   endtask

   task automatic run_dhcp(input int exp_next, input int exp_after);
      int expect_seq [3];
      expect_seq = '{0, exp_next, exp_after};
      for (int c = 0; c < 3; c++) begin
         drive_edge();
         do_dhcp = (c == 0);
         @(negedge m_axis_aclk);
         compare_values("dhcp request pulse", expect_seq[c], dhcp_start);
      end
   endtask

   initial begin
      m_axis_aresetn = 1'b0;
      rx_valid       = 1'b0;
      rx_beat        = '0;
      chan_req       = '{default: '0};
      core_ready     = 1'b0;
      core_result    = udp_hub_pkg::tx_idle;
      second_tick    = 1'b0;
      do_dhcp        = 1'b0;
      cmds           = 0;
      repeat (2) @(posedge m_axis_aclk);
      #1;
      m_axis_aresetn = 1'b1;
      @(negedge m_axis_aclk);
      compare_values("reset rx channel valid", 0, rx_chan_valid);
      compare_values("reset core start and valid", 0, {core_req.start, core_req.valid});
      compare_values("reset dhcp start", 0, dhcp_start);
      for (int i = 0; i < NCH; i++) begin
         compare_values("reset channel response", {1'b0, udp_hub_pkg::tx_idle}, chan_rsp[i]);
      end
      fd = $fopen("bench/udp_hub_stim.txt", "r");
      if (fd == 0) begin
         abort_run("cannot open the stimulus file bench/udp_hub_stim.txt");
      end
      // opcode first, hex operands on the rest of the line
      while ($fscanf(fd, "%s", op) == 1) begin
         void'($fgets(rest, fd));
         f = '{default: 0};
         void'($sscanf(rest, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]));
         if (op != "#") begin
            cmds++;
         end
         case (op)
            "#":     ;
            "rx":    run_rx(f[0], f[1], f[2], f[3], f[4]);
            "tx":    run_tx(f[0], f[1], f[2], f[3], f[4], f[5]);
            "tick":  run_ticks(f[0], f[1]);
            "dhcp":  run_dhcp(f[0], f[1]);
            default: abort_run({"unknown opcode in the stimulus file: ", op});
         endcase
      end
      $fclose(fd);
      if (cmds == 0) begin
         abort_run("the stimulus file holds no commands");
      end
      $display("Verification passed");
      $finish;
   end

endmodule

// File: bench/udp_hub_stim.txt
# opcode, then hex operands: rx dst_port data start last exp_chan_valid
# tx req_mask length result(2 done, 3 error) grant0 grant1 grant2 (3 = none)
# tick count exp_pulses, dhcp exp_pulse exp_after
rx 0044 a5 1 0 1
rx 4859 3c 0 0 2
rx 4858 7e 0 1 4
rx 1234 11 1 1 0
rx 0043 22 0 0 0
rx 4858 ff 1 1 4
tx 1 5 2 0 3 3
tx 2 3 3 1 3 3
tx 4 6 2 2 3 3
tx 6 4 2 1 2 3
tx 7 3 3 0 1 2
tx 5 a 2 0 2 3
tick 6 0
tick 1 1
tick 5 0
dhcp 1 0
dhcp 1 0

// File: udp_port_hub.f
hdl/udp_hub_pkg.sv
hdl/udp_rx_dispatch.sv
hdl/udp_tx_arbiter.sv
hdl/dhcp_kick_timer.sv
hdl/udp_port_hub.sv
bench/udp_port_hub_sva.sv
bench/udp_port_hub_tb.sv

// File: Bender.yml
package:
  name: udp_port_hub

sources:
  - hdl/udp_hub_pkg.sv
  - hdl/udp_rx_dispatch.sv
  - hdl/udp_tx_arbiter.sv
  - hdl/dhcp_kick_timer.sv
  - hdl/udp_port_hub.sv
  - target: test
    files:
      - bench/udp_port_hub_sva.sv
      - bench/udp_port_hub_tb.sv
